// File: reflex.f
+incdir+logic
logic/reflex_pkg.sv
logic/spike_tally_if.sv
logic/param_bank.sv
logic/spike_tally.sv
logic/motor_path.sv
logic/readout_mux.sv
logic/reflex_top.sv
sim/tb_reflex.sv

// File: Makefile
TOP = tb_reflex
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f reflex.f --top-module reflex_top
	verilator --lint-only --timing -f reflex.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f reflex.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/tb_reflex.sv
`timescale 1ns/1ps
`default_nettype none

`include "reflex_params.svh"

module tb_reflex
    import reflex_pkg::*;
();

    // long enough to clip a 16-bit count
    localparam int SAT_WINDOW  = 70000;
    // all tests together where the saturation window dominates
    localparam int TEST_CYCLES = SAT_WINDOW + 1500;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic               ep50trig;
    logic               reset_sim;
    logic               i_param_load;
    logic        [1:0]  i_param_sel;
    logic        [15:0] i_param_hi;
    logic        [15:0] i_param_lo;
    logic               i_sn_spike;
    logic               i_mn_spike;
    logic               i_ext_spike;
    logic signed [31:0] i_syn_current;
    logic        [7:0]  i_rd_addr;
    logic        [15:0] o_rd_data;
    logic               o_sn_window_done;
    logic               o_mn_window_done;

    // reference model state
    logic        [31:0] m_window;
    logic signed [31:0] m_gain;
    logic               m_merge;
    logic signed [31:0] m_scaled;
    logic               m_merged;
    logic        [15:0] m_rd;
    longint             m_prod;
    // window counters with index 0 sensory and 1 motor
    int unsigned        t_pos [2];
    int unsigned        t_len [2];
    int unsigned        t_hits [2];
    logic        [15:0] t_count [2];
    logic               t_ovf [2];
    logic               t_done [2];

    int errors;
    int checks;
    int errors_at_start;
    int n_pass;
    int n_fail;
    int cycles;
    bit check_en;

    reflex_top uut
    (
        .ep50trig         (ep50trig),
        .reset_sim        (reset_sim),
        .i_param_load     (i_param_load),
        .i_param_sel      (i_param_sel),
        .i_param_hi       (i_param_hi),
        .i_param_lo       (i_param_lo),
        .i_sn_spike       (i_sn_spike),
        .i_mn_spike       (i_mn_spike),
        .i_ext_spike      (i_ext_spike),
        .i_syn_current    (i_syn_current),
        .i_rd_addr        (i_rd_addr),
        .o_rd_data        (o_rd_data),
        .o_sn_window_done (o_sn_window_done),
        .o_mn_window_done (o_mn_window_done)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #2 ep50trig = ~ep50trig;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_reset();
        m_window = 32'd9;
        m_gain   = 32'sd1;
        m_merge  = 1'b1;
        m_scaled = '0;
        m_merged = 1'b0;
        m_rd     = '0;
        for (int k = 0; k < 2; k++)
        begin
            t_pos[k]   = 0;
            t_len[k]   = 1;
            t_hits[k]  = 0;
            t_count[k] = '0;
            t_ovf[k]   = 1'b0;
            t_done[k]  = 1'b0;
        end
    endtask

    // one cycle of a window counter
    task automatic tally_step(input int k, input logic spike);
        // length fixed at window start and zero acts as one
        if (t_pos[k] == 0)
            t_len[k] = (m_window == 0) ? 1 : m_window;
        if (spike)
            t_hits[k] = t_hits[k] + 1;
        t_done[k] = 1'b0;
        if (t_pos[k] == t_len[k] - 1)
        begin
            t_done[k]  = 1'b1;
            t_ovf[k]   = (t_hits[k] > 65535);
            t_count[k] = t_ovf[k] ? 16'hffff : 16'(t_hits[k]);
            t_hits[k]  = 0;
            t_pos[k]   = 0;
        end
        else
            t_pos[k] = t_pos[k] + 1;
    endtask

    function automatic logic [15:0] model_word(input logic [7:0] addr);
        case (addr)
            `REFLEX_RD_SYN_LO: return m_scaled[15:0];
            `REFLEX_RD_SYN_HI: return m_scaled[31:16];
            `REFLEX_RD_SN_CNT: return t_count[0];
            `REFLEX_RD_MN_CNT: return t_count[1];
            `REFLEX_RD_STATUS: return {14'd0, t_ovf[1], t_ovf[0]};
            default:           return 16'd0;
        endcase
    endfunction

    always @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            model_reset();
        else
        begin
            // readout and counters see the state before this edge
            m_rd = model_word(i_rd_addr);
            tally_step(0, i_sn_spike);
            tally_step(1, m_merged);
            m_merged = i_mn_spike | (i_ext_spike & m_merge);
            m_prod   = longint'(i_syn_current) * longint'(m_gain);
            m_scaled = m_prod[31:0];
            if (i_param_load)
            begin
                case (i_param_sel)
                    SEL_WINDOW:   m_window = {i_param_hi, i_param_lo};
                    SEL_SYN_GAIN: m_gain = signed'({i_param_hi, i_param_lo});
                    SEL_MERGE:    m_merge = ({i_param_hi, i_param_lo} != 32'd0);
                    default:      m_window = m_window;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking and cycle limit
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // mid-cycle compare against the model on every cycle
    always @(negedge ep50trig)
    begin
        if (check_en)
        begin
            check_value("o_rd_data", 32'(o_rd_data), 32'(m_rd));
            check_value("o_sn_window_done", 32'(o_sn_window_done), 32'(t_done[0]));
            check_value("o_mn_window_done", 32'(o_mn_window_done), 32'(t_done[1]));
        end
    end

    always @(posedge ep50trig)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("run stopped after %0d cycles without finishing the tests", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // inputs change 1 ns after the edge
    task automatic step();
        @(posedge ep50trig);
        #1;
    endtask

    task automatic drive_spikes();
        i_sn_spike    = ($urandom_range(0, 1) == 1);
        i_mn_spike    = ($urandom_range(0, 3) == 0);
        i_ext_spike   = ($urandom_range(0, 3) == 0);
        i_syn_current = $urandom;
    endtask

    function automatic logic done_flag(input int k);
        return (k == 0) ? o_sn_window_done : o_mn_window_done;
    endfunction

    task automatic run_until_done(input int k, input bit shuffle);
        do
        begin
            step();
            if (shuffle)
                drive_spikes();
        end
        while (!done_flag(k));
    endtask

    task automatic load_param(input param_sel_e sel, input logic [31:0] value);
        i_param_load = 1'b1;
        i_param_sel  = sel;
        i_param_hi   = value[31:16];
        i_param_lo   = value[15:0];
        step();
        i_param_load = 1'b0;
    endtask

    task automatic read_word(input logic [7:0] addr, output logic [15:0] data);
        i_rd_addr = addr;
        step();
        data = o_rd_data;
    endtask

    task automatic open_test();
        errors_at_start = errors;
    endtask

    task automatic close_test(input string name);
        if (errors == errors_at_start)
        begin
            n_pass++;
            $display("test %s: passed", name);
        end
        else
        begin
            n_fail++;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_defaults();
        int          n;
        logic [15:0] data;
        logic [31:0] cur;
        open_test();
        n = 0;
        // counts and status stay 0 through the first window
        do
        begin
            case (n % 3)
                0:       i_rd_addr = `REFLEX_RD_SN_CNT;
                1:       i_rd_addr = `REFLEX_RD_MN_CNT;
                default: i_rd_addr = `REFLEX_RD_STATUS;
            endcase
            step();
            n++;
            check_value("o_rd_data", 32'(o_rd_data), 32'd0);
        end
        while (!o_sn_window_done);
        check_value("first sn window length", 32'(n), 32'd9);
        // unit gain passes the current through
        cur = $urandom;
        i_syn_current = cur;
        step();
        read_word(`REFLEX_RD_SYN_LO, data);
        check_value("syn scaled lo", 32'(data), 32'(cur[15:0]));
        read_word(`REFLEX_RD_SYN_HI, data);
        check_value("syn scaled hi", 32'(data), 32'(cur[31:16]));
        close_test("reset_defaults");
    endtask

    task automatic test_param_load();
        int          n;
        int unsigned len;
        logic [31:0] gain;
        logic [31:0] cur;
        logic [15:0] lo;
        logic [15:0] hi;
        longint      expect_prod;
        open_test();
        for (int i = 0; i < 4; i++)
        begin
            len = $urandom_range(3, 24);
            load_param(SEL_WINDOW, len);
            if (!o_sn_window_done)
                run_until_done(0, 1'b0);
            repeat (2)
            begin
                n = 0;
                do
                begin
                    step();
                    n++;
                end
                while (!o_sn_window_done);
                check_value("sn window spacing", 32'(n), len);
            end
            gain = $urandom;
            load_param(SEL_SYN_GAIN, gain);
            cur = $urandom;
            i_syn_current = cur;
            step();
            read_word(`REFLEX_RD_SYN_LO, lo);
            read_word(`REFLEX_RD_SYN_HI, hi);
            expect_prod = longint'(signed'(cur)) * longint'(signed'(gain));
            check_value("syn scaled", {hi, lo}, expect_prod[31:0]);
        end
        close_test("param_load");
    endtask

    task automatic test_sensory_count();
        logic [15:0] data;
        logic [15:0] exp;
        open_test();
        load_param(SEL_WINDOW, $urandom_range(5, 16));
        repeat (6)
        begin
            run_until_done(0, 1'b1);
            exp = t_count[0];
            read_word(`REFLEX_RD_SN_CNT, data);
            check_value("sn count", 32'(data), 32'(exp));
        end
        close_test("sensory_count");
    endtask

    task automatic test_merging();
        logic [15:0] data;
        logic [15:0] exp;
        open_test();
        // merge on first and then motor spikes alone
        for (int m = 1; m >= 0; m--)
        begin
            load_param(SEL_MERGE, m);
            repeat (5)
            begin
                run_until_done(1, 1'b1);
                exp = t_count[1];
                read_word(`REFLEX_RD_MN_CNT, data);
                check_value("mn count", 32'(data), 32'(exp));
            end
        end
        close_test("merging");
    endtask

    task automatic test_saturation();
        logic [15:0] data;
        open_test();
        // sensory and motor spikes held high so both counters clip
        i_mn_spike  = 1'b1;
        i_ext_spike = 1'b0;
        i_sn_spike  = 1'b1;
        load_param(SEL_WINDOW, SAT_WINDOW);
        if (!o_sn_window_done)
            run_until_done(0, 1'b0);
        // long window now open with a short one queued behind it
        load_param(SEL_WINDOW, 8);
        run_until_done(0, 1'b0);
        read_word(`REFLEX_RD_SN_CNT, data);
        check_value("sn count saturated", 32'(data), 32'hffff);
        read_word(`REFLEX_RD_MN_CNT, data);
        check_value("mn count saturated", 32'(data), 32'hffff);
        read_word(`REFLEX_RD_STATUS, data);
        check_value("status sn overflow", 32'(data[0]), 32'd1);
        check_value("status mn overflow", 32'(data[1]), 32'd1);
        check_value("status word", 32'(data), 32'(model_word(`REFLEX_RD_STATUS)));
        i_sn_spike = 1'b0;
        i_mn_spike = 1'b0;
        run_until_done(0, 1'b0);
        read_word(`REFLEX_RD_STATUS, data);
        check_value("status overflow cleared", 32'(data), 32'd0);
        close_test("saturation");
    endtask

    task automatic test_readout();
        open_test();
        for (int i = 0; i < 200; i++)
        begin
            case ($urandom_range(0, 5))
                0:       i_rd_addr = `REFLEX_RD_SYN_LO;
                1:       i_rd_addr = `REFLEX_RD_SYN_HI;
                2:       i_rd_addr = `REFLEX_RD_SN_CNT;
                3:       i_rd_addr = `REFLEX_RD_MN_CNT;
                4:       i_rd_addr = `REFLEX_RD_STATUS;
                default: i_rd_addr = 8'($urandom);
            endcase
            drive_spikes();
            step();
            check_value("o_rd_data", 32'(o_rd_data), 32'(m_rd));
        end
        close_test("readout");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        void'($urandom(32'h987d));
        errors        = 0;
        checks        = 0;
        n_pass        = 0;
        n_fail        = 0;
        cycles        = 0;
        check_en      = 1'b0;
        reset_sim     = 1'b1;
        i_param_load  = 1'b0;
        i_param_sel   = '0;
        i_param_hi    = '0;
        i_param_lo    = '0;
        i_sn_spike    = 1'b0;
        i_mn_spike    = 1'b0;
        i_ext_spike   = 1'b0;
        i_syn_current = '0;
        i_rd_addr     = '0;
        // two cycles in reset
        step();
        step();
        reset_sim = 1'b0;
        check_en  = 1'b1;
        test_reset_defaults();
        test_param_load();
        test_sensory_count();
        test_merging();
        test_saturation();
        test_readout();
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 n_pass, n_fail, checks, errors);
        if (errors == 0 && n_fail == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/reflex_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "reflex_params.svh"

module reflex_top
    import reflex_pkg::*;
(
    input  wire logic                               ep50trig,
    input  wire logic                               reset_sim,
    // host parameter load
    input  wire logic                               i_param_load,
    input  wire logic         [1:0]                 i_param_sel,
    input  wire logic         [`REFLEX_DATA_W-1:0]  i_param_hi,
    input  wire logic         [`REFLEX_DATA_W-1:0]  i_param_lo,
    // spike and current sources
    input  wire logic                               i_sn_spike,
    input  wire logic                               i_mn_spike,
    input  wire logic                               i_ext_spike,
    input  wire logic signed  [`REFLEX_PARAM_W-1:0] i_syn_current,
    // readout
    input  wire logic         [7:0]                 i_rd_addr,
    output logic              [`REFLEX_DATA_W-1:0]  o_rd_data,
    output logic                                    o_sn_window_done,
    output logic                                    o_mn_window_done
);

    logic        [`REFLEX_PARAM_W-1:0] window_len;
    logic signed [`REFLEX_PARAM_W-1:0] syn_gain;
    logic                              merge_en;
    logic signed [`REFLEX_PARAM_W-1:0] syn_scaled;

    // sensory and motor counter results
    spike_tally_if sn_tally_bus ();
    spike_tally_if mn_tally_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // parameters, sensory count, motor path, readout
    ////////////////////////////////////////////////////////////////////////////

    param_bank u_param_bank
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_param_load (i_param_load),
        .i_param_sel  (param_sel_e'(i_param_sel)),
        .i_param_hi   (i_param_hi),
        .i_param_lo   (i_param_lo),
        .o_window_len (window_len),
        .o_syn_gain   (syn_gain),
        .o_merge_en   (merge_en)
    );

    // sensory spikes counted straight from the input
    spike_tally u_sn_tally
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_spike      (i_sn_spike),
        .i_window_len (window_len),
        .o_tally      (sn_tally_bus)
    );

    motor_path u_motor_path
    (
        .ep50trig      (ep50trig),
        .reset_sim     (reset_sim),
        .i_syn_current (i_syn_current),
        .i_syn_gain    (syn_gain),
        .i_mn_spike    (i_mn_spike),
        .i_ext_spike   (i_ext_spike),
        .i_merge_en    (merge_en),
        .i_window_len  (window_len),
        .o_syn_scaled  (syn_scaled),
        .o_tally       (mn_tally_bus)
    );

    readout_mux u_readout_mux
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_rd_addr    (rd_addr_e'(i_rd_addr)),
        .i_syn_scaled (syn_scaled),
        .i_sn_tally   (sn_tally_bus),
        .i_mn_tally   (mn_tally_bus),
        .o_rd_data    (o_rd_data)
    );

    assign o_sn_window_done = sn_tally_bus.window_done;
    assign o_mn_window_done = mn_tally_bus.window_done;

endmodule

`default_nettype wire

// File: logic/readout_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "reflex_params.svh"

module readout_mux
    import reflex_pkg::*;
(
    input  wire logic                               ep50trig,
    input  wire logic                               reset_sim,
    input  wire rd_addr_e                           i_rd_addr,
    input  wire logic signed  [`REFLEX_PARAM_W-1:0] i_syn_scaled,
    spike_tally_if.sink                             i_sn_tally,
    spike_tally_if.sink                             i_mn_tally,
    output logic              [`REFLEX_DATA_W-1:0]  o_rd_data
);

    logic [`REFLEX_DATA_W-1:0] rd_word;

    // word select, unmapped addresses read 0
    always_comb
    begin
        case (i_rd_addr)
            RD_SYN_LO: rd_word = i_syn_scaled[`REFLEX_DATA_W-1:0];
            RD_SYN_HI: rd_word = i_syn_scaled[`REFLEX_PARAM_W-1:`REFLEX_DATA_W];
            RD_SN_CNT: rd_word = i_sn_tally.count;
            RD_MN_CNT: rd_word = i_mn_tally.count;
            // bit 1 motor overflow, bit 0 sensory overflow
            RD_STATUS: rd_word = {{(`REFLEX_DATA_W-2){1'b0}}, i_mn_tally.overflow,
                                  i_sn_tally.overflow};
            default:   rd_word = '0;
        endcase
    end

    // one cycle from address to data
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_rd_data <= '0;
        else
            o_rd_data <= rd_word;
    end

endmodule

`default_nettype wire

// File: logic/motor_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "reflex_params.svh"

module motor_path
(
    input  wire logic                               ep50trig,
    input  wire logic                               reset_sim,
    input  wire logic signed  [`REFLEX_PARAM_W-1:0] i_syn_current,
    input  wire logic signed  [`REFLEX_PARAM_W-1:0] i_syn_gain,
    input  wire logic                               i_mn_spike,
    input  wire logic                               i_ext_spike,
    input  wire logic                               i_merge_en,
    input  wire logic         [`REFLEX_PARAM_W-1:0] i_window_len,
    output logic signed       [`REFLEX_PARAM_W-1:0] o_syn_scaled,
    spike_tally_if.source                           o_tally
);

    // full signed product, low half kept
    logic signed [2*`REFLEX_PARAM_W-1:0] syn_prod;
    // short-latency spike OR'd with the long-latency one
    logic                                merged_d;
    logic                                merged_q;

    ////////////////////////////////////////////////////////////////////////////
    // gain scaling and spike merge
    ////////////////////////////////////////////////////////////////////////////

    assign syn_prod = i_syn_current * i_syn_gain;
    // external spike passes only in trigger mode
    assign merged_d = i_mn_spike | (i_ext_spike & i_merge_en);

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_syn_scaled <= '0;
            merged_q     <= 1'b0;
        end
        else
        begin
            // truncate, wraps like the 32-bit wire-out
            o_syn_scaled <= signed'(syn_prod[`REFLEX_PARAM_W-1:0]);
            merged_q     <= merged_d;
        end
    end

    // motor counter, one cycle behind the inputs
    spike_tally u_mn_tally
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_spike      (merged_q),
        .i_window_len (i_window_len),
        .o_tally      (o_tally)
    );

endmodule

`default_nettype wire

// File: logic/spike_tally.sv
`timescale 1ns/1ps
`default_nettype none

`include "reflex_params.svh"

module spike_tally
(
    input  wire logic                        ep50trig,
    input  wire logic                        reset_sim,
    input  wire logic                        i_spike,
    input  wire logic [`REFLEX_PARAM_W-1:0]  i_window_len,
    spike_tally_if.source                    o_tally
);

    localparam logic [`REFLEX_PARAM_W-1:0] ONE = 1;

    // cycles left in the window, 0 marks a window start
    logic [`REFLEX_PARAM_W-1:0] left_q;
    logic [`REFLEX_PARAM_W-1:0] eff_len;
    logic [`REFLEX_PARAM_W-1:0] cur_left;
    logic                       last_cycle;
    // open window count and its clip flag
    logic [`REFLEX_TALLY_W-1:0] run_q;
    logic [`REFLEX_TALLY_W-1:0] run_next;
    logic                       clip;
    logic                       ovf_run_q;
    // per-window latches
    logic [`REFLEX_TALLY_W-1:0] count_q;
    logic                       ovf_q;
    logic                       done_q;

    ////////////////////////////////////////////////////////////////////////////
    // window timing and saturating count
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // zero length acts as one
        eff_len    = (i_window_len == '0) ? ONE : i_window_len;
        // new length only sampled at the window start
        cur_left   = (left_q == '0) ? eff_len : left_q;
        last_cycle = (cur_left == ONE);
        // spike lost when already all ones
        clip       = i_spike & (&run_q);
        run_next   = (i_spike && !clip) ? run_q + 1'b1 : run_q;
    end

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            left_q    <= '0;
            run_q     <= '0;
            ovf_run_q <= 1'b0;
            count_q   <= '0;
            ovf_q     <= 1'b0;
            done_q    <= 1'b0;
        end
        else
        begin
            left_q <= cur_left - ONE;
            done_q <= last_cycle;
            if (last_cycle)
            begin
                // close the window, this cycle's spike included
                count_q   <= run_next;
                ovf_q     <= ovf_run_q | clip;
                run_q     <= '0;
                ovf_run_q <= 1'b0;
            end
            else
            begin
                run_q     <= run_next;
                ovf_run_q <= ovf_run_q | clip;
            end
        end
    end

    assign o_tally.count       = count_q;
    assign o_tally.overflow    = ovf_q;
    assign o_tally.window_done = done_q;
    assign o_tally.running     = run_q;

endmodule

`default_nettype wire

// File: logic/param_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "reflex_params.svh"

module param_bank
    import reflex_pkg::*;
(
    input  wire logic                              ep50trig,
    input  wire logic                              reset_sim,
    input  wire logic                              i_param_load,
    input  wire param_sel_e                        i_param_sel,
    input  wire logic        [`REFLEX_DATA_W-1:0]  i_param_hi,
    input  wire logic        [`REFLEX_DATA_W-1:0]  i_param_lo,
    output logic             [`REFLEX_PARAM_W-1:0] o_window_len,
    output logic signed      [`REFLEX_PARAM_W-1:0] o_syn_gain,
    output logic                                   o_merge_en
);

    // full word from the two host halves
    logic [`REFLEX_PARAM_W-1:0] load_word;

    assign load_word = {i_param_hi, i_param_lo};

    ////////////////////////////////////////////////////////////////////////////
    // host registers
    ////////////////////////////////////////////////////////////////////////////

    // one clock for all, select picks the target
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_window_len <= `REFLEX_WINDOW_RST;
            o_syn_gain   <= `REFLEX_GAIN_RST;
            o_merge_en   <= `REFLEX_MERGE_RST;
        end
        else if (i_param_load)
        begin
            case (i_param_sel)
                // window length in cycles
                SEL_WINDOW:
                begin
                    o_window_len <= load_word;
                end
                // signed synaptic gain
                SEL_SYN_GAIN:
                begin
                    o_syn_gain <= signed'(load_word);
                end
                // trigger mode, any non-zero word turns merging on
                SEL_MERGE:
                begin
                    o_merge_en <= |load_word;
                end
                // reserved select, nothing loads
                default:
                begin
                    o_merge_en <= o_merge_en;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/spike_tally_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "reflex_params.svh"

// results of one windowed spike counter
interface spike_tally_if;

    // spikes in the last closed window, saturated
    logic [`REFLEX_TALLY_W-1:0] count;
    // one-cycle pulse, count and overflow just latched
    logic                       window_done;
    // count clipped during that window
    logic                       overflow;
    // live count of the open window
    logic [`REFLEX_TALLY_W-1:0] running;

    // counter side
    modport source (output count, output window_done, output overflow, output running);

    // readout side
    modport sink (input count, input window_done, input overflow, input running);

endinterface

`default_nettype wire

// File: logic/reflex_pkg.sv
`default_nettype none

`include "reflex_params.svh"

package reflex_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // host parameter select
    ////////////////////////////////////////////////////////////////////////////

    // code 3 reserved, load ignored
    typedef enum logic [1:0]
    {
        SEL_WINDOW   = 2'd0,
        SEL_SYN_GAIN = 2'd1,
        SEL_MERGE    = 2'd2
    } param_sel_e;

    ////////////////////////////////////////////////////////////////////////////
    // readout address map
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [7:0]
    {
        RD_SYN_LO = `REFLEX_RD_SYN_LO,
        RD_SYN_HI = `REFLEX_RD_SYN_HI,
        RD_SN_CNT = `REFLEX_RD_SN_CNT,
        RD_MN_CNT = `REFLEX_RD_MN_CNT,
        RD_STATUS = `REFLEX_RD_STATUS
    } rd_addr_e;

endpackage

`default_nettype wire

// File: logic/reflex_params.svh
`ifndef REFLEX_PARAMS_SVH
`define REFLEX_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////////////////////

// host wire word, one endpoint half
`define REFLEX_DATA_W 16
// full parameter and synaptic current width
`define REFLEX_PARAM_W 32
// per-window spike count
`define REFLEX_TALLY_W 16

////////////////////////////////////////////////////////////////////////////
// reset defaults and readout addresses
////////////////////////////////////////////////////////////////////////////

`define REFLEX_WINDOW_RST 32'd9
`define REFLEX_GAIN_RST 32'sd1
// trigger mode on, long-latency spikes merged
`define REFLEX_MERGE_RST 1'b1

// wire-out style addresses
`define REFLEX_RD_SYN_LO 8'h20
`define REFLEX_RD_SYN_HI 8'h21
`define REFLEX_RD_SN_CNT 8'h24
`define REFLEX_RD_MN_CNT 8'h26
`define REFLEX_RD_STATUS 8'h28

`endif
